// File: logic/cache_pkg.sv
/*
  Geometry and shared types of the two-way write-back data cache.
  Modules import this inside their bodies and use scoped names in their port lists.
  The address union is split from this geometry, so the sizes are fixed here.
*/
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////
  parameter int ADR_W  = 32;                            // byte address
  parameter int WAYS   = 2;
  parameter int IDX_W  = 4;                             // 16 sets
  parameter int WORD_W = 2;                             // 4 words per line
  parameter int TAG_W  = ADR_W - IDX_W - WORD_W - 2;    // 24
  parameter int LINE_W = 32 << WORD_W;                  // 128 bit line
  parameter int SETS   = 1 << IDX_W;

  // address as seen by the arrays
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] word;
    logic [1:0]        byte_ofs;  // always 0 on the bus
  } cache_adr_s;

  // raw for the bus side, fld for the lookup
  typedef union packed {
    logic [ADR_W-1:0] raw;
    cache_adr_s       fld;
  } cache_adr_u;

  typedef enum logic [2:0] {
    IDLE,       // wait for request or invalidate
    LOOKUP,     // ram read, then compare
    EVICT_RD,   // copy victim line to the write-back buffer
    EVICT_WB,   // four write beats
    FILL,       // four read beats
    DONE        // one idle cycle after ack
  } ctrl_state_e;

endpackage

// File: logic/cache_array_if.sv
/*
  Bundle between the cache controller and the two storage blocks.
  The controller drives index, way and write strobes, the stores answer with
  hit and victim info (tag side) and read words (data side).
*/
`timescale 1ns/1ps

interface cache_array_if;
  import cache_pkg::*;

  // controller to stores
  logic [IDX_W-1:0]  idx;          // set, read every cycle
  logic [WORD_W-1:0] word;         // word in line, beat number during bursts
  logic [WAYS-1:0]   way_sel;      // one-hot
  logic              tag_we;
  logic [TAG_W-1:0]  tag_wdat;     // request tag, also the compare tag
  logic              fill_dirty;   // dirty value written with tag_we
  logic              data_we;      // byte write on a write hit
  logic [3:0]        be;
  logic [31:0]       wdat;
  logic              fill_line;    // one fill beat, full word
  logic              buf_load;
  logic              inval;        // drop all valid bits

  // tag store answers
  logic              hit;
  logic [WAYS-1:0]   hit_way;
  logic [WAYS-1:0]   victim_way;
  logic              victim_dirty;
  logic [TAG_W-1:0]  victim_tag;

  // data store answers
  logic [31:0]       rd_word;
  logic [31:0]       buf_word;

  modport ctrl (
    output idx, word, way_sel, tag_we, tag_wdat, fill_dirty, data_we, be, wdat,
           fill_line, buf_load, inval,
    input  hit, hit_way, victim_way, victim_dirty, victim_tag, rd_word, buf_word
  );

  modport tag (
    input  idx, way_sel, tag_we, tag_wdat, fill_dirty, inval,
    output hit, hit_way, victim_way, victim_dirty, victim_tag
  );

  modport data (
    input  idx, word, way_sel, data_we, be, wdat, fill_line, buf_load, hit_way,
    output rd_word, buf_word
  );

endinterface

// File: logic/beat_counter.sv
/*
  Beat counter for line bursts. Held at zero while disabled, steps on each
  acked beat and flags the last beat of a line while it is being acked.
*/
`timescale 1ns/1ps

module beat_counter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         en_i,
  input  logic                         ack_i,
  output logic [cache_pkg::WORD_W-1:0] beat_o,
  output logic                         last_o
);
  import cache_pkg::*;

  logic [WORD_W-1:0] beat_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      beat_q <= '0;
    else if (!en_i)
      beat_q <= '0;               // no burst running
    else if (ack_i)
      beat_q <= beat_q + 1'b1;    // wraps to 0 after the last word
  end

  assign beat_o = beat_q;
  assign last_o = en_i & ack_i & (&beat_q);   // fourth beat acked

endmodule

// File: logic/tag_store.sv
/*
  Tag side of the cache. One tag ram per way with a registered read,
  valid and dirty bits in flops, one replacement bit per set.
  Produces the hit vector and the victim way, tag and dirty state
  for the set read in the previous cycle.
*/
`timescale 1ns/1ps

module tag_store (
  input logic        clk_i,
  input logic        rst_ni,
  cache_array_if.tag arr
);
  import cache_pkg::*;

  logic [TAG_W-1:0] tag_ram [WAYS][SETS];
  logic [TAG_W-1:0] tag_q   [WAYS];   // ram read data
  logic [SETS-1:0]  valid_q [WAYS];
  logic [SETS-1:0]  dirty_q [WAYS];
  logic [SETS-1:0]  repl_q;           // two ways, one bit names the victim
  logic [IDX_W-1:0] rd_idx_q;         // set behind tag_q
  logic [WAYS-1:0]  vld_way;
  logic [WAYS-1:0]  drt_way;
  logic [WAYS-1:0]  hit_vec;
  logic [WAYS-1:0]  vict;
  logic [TAG_W-1:0] vtag;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    always_ff @(posedge clk_i)
    begin
      if (arr.tag_we && arr.way_sel[w])
        tag_ram[w][arr.idx] <= arr.tag_wdat;
      tag_q[w] <= tag_ram[w][arr.idx];   // old data on same-cycle write
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      else
      begin
        if (arr.inval)
          valid_q[w] <= '0;              // whole cache at once
        else if (arr.tag_we && arr.way_sel[w])
          valid_q[w][arr.idx] <= 1'b1;
        if (arr.tag_we && arr.way_sel[w])
          dirty_q[w][arr.idx] <= arr.fill_dirty;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      repl_q   <= '0;
      rd_idx_q <= '0;
    end
    else
    begin
      rd_idx_q <= arr.idx;
      if (|arr.way_sel)
        repl_q[arr.idx] <= arr.way_sel[0];   // used way 0 -> replace way 1 next
    end
  end

  ////////////////////////////////////////////////////////////
  // compare and victim choice
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      vld_way[w] = valid_q[w][rd_idx_q];
      drt_way[w] = dirty_q[w][rd_idx_q];
      hit_vec[w] = vld_way[w] & (tag_q[w] == arr.tag_wdat);
    end
  end

  always_comb
  begin
    vict                   = '0;
    vict[repl_q[rd_idx_q]] = 1'b1;   // set full
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!vld_way[w])
      begin
        vict    = '0;
        vict[w] = 1'b1;              // lowest invalid way wins
      end
    end
    vtag = '0;
    for (int w = 0; w < WAYS; w++)
      if (vict[w])
        vtag = tag_q[w];
  end

  assign arr.hit          = |hit_vec;
  assign arr.hit_way      = hit_vec;
  assign arr.victim_way   = vict;
  assign arr.victim_dirty = |(vict & vld_way & drt_way);   // dirty only counts when valid
  assign arr.victim_tag   = vtag;

endmodule

// File: logic/data_store.sv
/*
  Data side of the cache. One line ram per way with a registered read,
  written by byte on write hits or by whole word on fill beats.
  Returns the requested word of the hit way and holds the victim line
  for the write-back burst.
*/
`timescale 1ns/1ps

module data_store (
  input logic         clk_i,
  input logic         rst_ni,
  cache_array_if.data arr
);
  import cache_pkg::*;

  logic [LINE_W-1:0] line_ram [WAYS][SETS];
  logic [LINE_W-1:0] line_q   [WAYS];   // ram read data
  logic [LINE_W-1:0] buf_q;             // write-back line buffer
  logic [LINE_W-1:0] hit_line;
  logic [LINE_W-1:0] vict_line;
  logic [3:0]        wr_be;

  assign wr_be = arr.fill_line ? 4'hf : arr.be;   // fill writes the full word

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    always_ff @(posedge clk_i)
    begin
      if ((arr.data_we || arr.fill_line) && arr.way_sel[w])
      begin
        for (int b = 0; b < 4; b++)
          if (wr_be[b])
            line_ram[w][arr.idx][arr.word*32 + b*8 +: 8] <= arr.wdat[b*8 +: 8];
      end
      line_q[w] <= line_ram[w][arr.idx];
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux and victim buffer
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_line  = '0;
    vict_line = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (arr.hit_way[w])
        hit_line = line_q[w];
      if (arr.way_sel[w])
        vict_line = line_q[w];   // way_sel is the victim during EVICT_RD
    end
  end

  assign arr.rd_word = hit_line[arr.word*32 +: 32];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      buf_q <= '0;
    else if (arr.buf_load)
      buf_q <= vict_line;
  end

  assign arr.buf_word = buf_q[arr.word*32 +: 32];   // word = beat number here

endmodule

// File: logic/cache_ctrl.sv
/*
  Cache sequencer. Registers a core request, looks it up in two cycles and
  either acks a hit or runs write-back and fill bursts on Wishbone classic,
  then retries the lookup. Beats are counted by the external beat counter.
*/
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic                         inval_i,
  input  logic [cache_pkg::ADR_W-1:0]  adr_i,
  input  logic [3:0]                   be_i,
  input  logic [31:0]                  wdat_i,
  output logic                         ack_o,
  output logic [31:0]                  rdat_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [cache_pkg::ADR_W-1:0]  wb_adr_o,
  output logic [31:0]                  wb_dat_o,
  input  logic [31:0]                  wb_dat_i,
  input  logic                         wb_ack_i,
  output logic                         beat_en_o,
  input  logic [cache_pkg::WORD_W-1:0] beat_i,
  input  logic                         last_i,
  cache_array_if.ctrl                  arr
);
  import cache_pkg::*;

  ctrl_state_e      state_q, state_d;
  cache_adr_u       req_q;      // request address, held until ack
  logic             we_q;
  logic [3:0]       be_q;
  logic [31:0]      wdat_q;
  logic             cmp_q;      // second lookup cycle, store outputs valid
  logic [WAYS-1:0]  way_q;      // way being evicted and refilled
  logic [TAG_W-1:0] vtag_q;     // tag of the evicted line
  logic             hit_cyc;
  logic             miss_cyc;
  cache_adr_u       wb_adr;

  assign hit_cyc  = (state_q == LOOKUP) & cmp_q & arr.hit;
  assign miss_cyc = (state_q == LOOKUP) & cmp_q & ~arr.hit;

  ////////////////////////////////////////////////////////////
  // state and control registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cmp_q   <= 1'b0;
      way_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      cmp_q   <= (state_q == LOOKUP) & ~cmp_q;  // read cycle, then compare cycle
      if (miss_cyc)
        way_q <= arr.victim_way;                // victim moves once repl updates
    end
  end

  // request payload
  always_ff @(posedge clk_i)
  begin
    if ((state_q == IDLE) && req_i)
    begin
      req_q.raw <= adr_i;
      we_q      <= we_i;
      be_q      <= be_i;
      wdat_q    <= wdat_i;
    end
    if (miss_cyc)
      vtag_q <= arr.victim_tag;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (req_i)
          state_d = LOOKUP;
      LOOKUP:
      begin
        if (hit_cyc)
          state_d = DONE;
        else if (miss_cyc)
          state_d = arr.victim_dirty ? EVICT_RD : FILL;  // clean victim is just dropped
      end
      EVICT_RD: state_d = EVICT_WB;
      EVICT_WB:
        if (last_i)
          state_d = FILL;
      FILL:
        if (last_i)
          state_d = LOOKUP;   // retry, line is in now
      DONE:     state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // array strobes
  ////////////////////////////////////////////////////////////
  assign arr.idx        = req_q.fld.idx;
  assign arr.word       = beat_en_o ? beat_i : req_q.fld.word;
  assign arr.tag_wdat   = req_q.fld.tag;
  assign arr.way_sel    = hit_cyc ? arr.hit_way :
                          (state_q inside {EVICT_RD, EVICT_WB, FILL}) ? way_q : '0;
  assign arr.data_we    = hit_cyc & we_q;
  assign arr.tag_we     = (hit_cyc & we_q) | ((state_q == FILL) & last_i);
  assign arr.fill_dirty = (state_q != FILL);   // write hit sets dirty, fill clears it
  assign arr.be         = be_q;
  assign arr.wdat       = (state_q == FILL) ? wb_dat_i : wdat_q;
  assign arr.fill_line  = (state_q == FILL) & wb_ack_i;
  assign arr.buf_load   = (state_q == EVICT_RD);
  assign arr.inval      = (state_q == IDLE) & inval_i & ~req_i;

  // wishbone master, address from victim tag or request tag
  always_comb
  begin
    wb_adr.raw      = '0;
    wb_adr.fld.tag  = (state_q == EVICT_WB) ? vtag_q : req_q.fld.tag;
    wb_adr.fld.idx  = req_q.fld.idx;
    wb_adr.fld.word = beat_i;                  // +4 per acked beat
  end

  assign beat_en_o = (state_q == EVICT_WB) | (state_q == FILL);
  assign wb_cyc_o  = beat_en_o;
  assign wb_stb_o  = beat_en_o;
  assign wb_we_o   = (state_q == EVICT_WB);
  assign wb_adr_o  = wb_adr.raw;
  assign wb_dat_o  = arr.buf_word;

  assign ack_o  = hit_cyc;       // single pulse, DONE follows
  assign rdat_o = arr.rd_word;

endmodule

// File: logic/cache_top.sv
/*
  Top level of the two-way write-back data cache.
  Core side is a req/ack port, memory side a Wishbone classic master.
  Holds only the controller, beat counter, tag and data stores and their wiring.
*/
`timescale 1ns/1ps

module cache_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // core side
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic                        inval_i,
  input  logic [cache_pkg::ADR_W-1:0] adr_i,
  input  logic [3:0]                  be_i,
  input  logic [31:0]                 wdat_i,
  output logic                        ack_o,
  output logic [31:0]                 rdat_o,
  // wishbone master
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [cache_pkg::ADR_W-1:0] wb_adr_o,
  output logic [31:0]                 wb_dat_o,
  input  logic [31:0]                 wb_dat_i,
  input  logic                        wb_ack_i
);
  import cache_pkg::*;

  logic [WORD_W-1:0] beat;
  logic              beat_en;
  logic              last;

  cache_array_if arr ();

  cache_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .we_i      (we_i),
    .inval_i   (inval_i),
    .adr_i     (adr_i),
    .be_i      (be_i),
    .wdat_i    (wdat_i),
    .ack_o     (ack_o),
    .rdat_o    (rdat_o),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .wb_dat_o  (wb_dat_o),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .beat_en_o (beat_en),
    .beat_i    (beat),
    .last_i    (last),
    .arr       (arr)
  );

  beat_counter u_beat (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (beat_en),
    .ack_i  (wb_ack_i),
    .beat_o (beat),
    .last_o (last)
  );

  tag_store u_tag (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr)
  );

  data_store u_data (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .arr    (arr)
  );

endmodule

// File: verif/wb_mem_model.sv
/*
  Wishbone classic slave memory for the cache testbench.
  Holds a 4 KB window in which every word starts as the inverse of its byte address.
  Each beat is acked after a random wait of 0 to 3 cycles, plus one cycle to register.
  The testbench reads mem and range_err through the hierarchy.
*/
`timescale 1ns/1ps

module wb_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  logic [31:0] mem [1024];     // word window, byte address bits 11:2
  logic [1:0]  wait_q;
  logic        armed_q;        // wait drawn for the current beat
  int          range_err;      // beats above the window
  integer      seed = 39044;

  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < 1024; i++)
        mem[i] <= ~(32'(i) << 2);
      ack_o     <= 1'b0;
      armed_q   <= 1'b0;
      wait_q    <= '0;
      dat_o     <= '0;
      range_err <= 0;
    end
    else if (ack_o || !(cyc_i && stb_i))
    begin
      ack_o   <= 1'b0;         // one ack per beat, master steps now
      armed_q <= 1'b0;
    end
    else if (!armed_q)
    begin
      wait_q  <= 2'($random(seed));
      armed_q <= 1'b1;
    end
    else if (wait_q != 2'd0)
      wait_q <= wait_q - 2'd1; // late ack is the only back-pressure
    else
    begin
      ack_o <= 1'b1;
      if (adr_i[31:12] != '0)
        range_err <= range_err + 1;
      if (we_i)
      begin
        for (int b = 0; b < 4; b++)
          if (sel_i[b])
            mem[adr_i[11:2]][b*8 +: 8] <= dat_i[b*8 +: 8];
      end
      else
        dat_o <= mem[adr_i[11:2]];   // valid while ack is high
    end
  end

endmodule

// File: verif/cache_tb.sv
/*
  Directed testbench for the two-way write-back cache.
  Drives the core port of cache_top, serves its Wishbone bursts from wb_mem_model
  and checks read data, hit latency, bus beats and written-back memory.
  core_view holds the word each address should read as seen from the core.
*/
`timescale 1ns/1ps

module cache_tb;

  localparam int TIMEOUT = 2000;   // whole run is near 500 cycles, four times that

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        we_i;
  logic        inval_i;
  logic [31:0] adr_i;
  logic [3:0]  be_i;
  logic [31:0] wdat_i;
  logic        ack_o;
  logic [31:0] rdat_o;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic        wb_ack;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;           // master to memory
  logic [31:0] wb_dat_r;           // memory to master

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  integer      seed   = 39044;
  logic [31:0] core_view [1024];
  logic [31:0] beat_adr [$];       // acked beats of the last access
  logic        beat_we  [$];
  logic [31:0] beat_dat [$];

  cache_top dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .we_i(we_i), .inval_i(inval_i),
    .adr_i(adr_i), .be_i(be_i), .wdat_i(wdat_i), .ack_o(ack_o), .rdat_o(rdat_o),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
  );

  wb_mem_model mem0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
    .adr_i(wb_adr), .sel_i(4'hf), .dat_i(wb_dat_w), .dat_o(wb_dat_r), .ack_o(wb_ack)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // bus monitor, ack is stable at the falling edge
  always @(negedge clk_i)
  begin
    if (wb_cyc && wb_stb && wb_ack)
    begin
      beat_adr.push_back(wb_adr);
      beat_we.push_back(wb_we);
      beat_dat.push_back(wb_we ? wb_dat_w : wb_dat_r);
    end
  end

  //////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////
  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                        input logic [3:0] be);
    logic [31:0] m;
    m = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        m[b*8 +: 8] = new_w[b*8 +: 8];   // enabled bytes only
    return m;
  endfunction

  // one core request, lat counts cycles from the sampling edge to ack
  task automatic access(input logic we, input logic [31:0] adr, input logic [3:0] be,
                        input logic [31:0] wdat, output logic [31:0] rdat, output int lat);
    int n;
    beat_adr.delete();
    beat_we.delete();
    beat_dat.delete();
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= we;
    adr_i  <= adr;
    be_i   <= be;
    wdat_i <= wdat;
    @(negedge clk_i);
    n = 1;                            // dut samples req at the next edge
    while (!ack_o)
    begin
      @(negedge clk_i);
      n++;
    end
    rdat = rdat_o;
    lat  = n - 1;
    @(posedge clk_i);
    req_i <= 1'b0;                    // low for at least one cycle
    we_i  <= 1'b0;
    if (we)
      core_view[adr[11:2]] = merge(core_view[adr[11:2]], wdat, be);
  endtask

  // four beats from a line base, write beats also carry the core view
  task automatic check_burst(input int first, input logic [31:0] base, input logic we);
    for (int k = 0; k < 4; k++)
    begin
      if (first + k < beat_adr.size())
      begin
        check("wb_adr_o", beat_adr[first+k], base + 32'(4*k));
        check("wb_we_o", 32'(beat_we[first+k]), 32'(we));
        if (we)
          check("wb_dat_o", beat_dat[first+k], core_view[int'(base[11:2]) + k]);
      end
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (errors == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////
  task automatic cold_miss_read();
    logic [31:0] rd;
    int          lat;
    int          e0;
    e0 = errors;
    check("ack_o", 32'(ack_o), 32'd0);
    check("wb_cyc_o", 32'(wb_cyc), 32'd0);
    check("wb_stb_o", 32'(wb_stb), 32'd0);
    check("wb_we_o", 32'(wb_we), 32'd0);
    access(1'b0, 32'h40, 4'hf, '0, rd, lat);
    check("rdat_o", rd, ~32'h40);
    check("bus beats", 32'(beat_adr.size()), 32'd4);
    check_burst(0, 32'h40, 1'b0);
    report("cold miss read", e0);
  endtask

  task automatic same_line_hit();
    logic [31:0] rd;
    int          lat;
    int          e0;
    e0 = errors;
    access(1'b0, 32'h48, 4'hf, '0, rd, lat);
    check("rdat_o", rd, ~32'h48);
    check("ack_o latency", 32'(lat), 32'd2);
    check("bus beats", 32'(beat_adr.size()), 32'd0);
    report("same line hit", e0);
  endtask

  task automatic write_merge(input logic [31:0] adr, input logic [3:0] be);
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] rd;
    int          lat;
    data = $random(seed);
    exp  = merge(core_view[adr[11:2]], data, be);
    access(1'b1, adr, be, data, rd, lat);
    check("ack_o latency", 32'(lat), 32'd2);
    access(1'b0, adr, 4'hf, '0, rd, lat);
    check("rdat_o", rd, exp);
    check("bus beats", 32'(beat_adr.size()), 32'd0);
  endtask

  task automatic partial_write_hits();
    int e0;
    e0 = errors;
    write_merge(32'h44, 4'b0101);
    write_merge(32'h4c, 4'b1100);
    write_merge(32'h40, 4'b0010);
    report("partial write hits", e0);
  endtask

  // lines 0x010, 0x110 and 0x210 all index set 1
  task automatic set_conflict_evict();
    logic [31:0] rd;
    int          lat;
    int          e0;
    e0 = errors;
    access(1'b0, 32'h010, 4'hf, '0, rd, lat);      // fills way 0
    access(1'b0, 32'h110, 4'hf, '0, rd, lat);      // fills way 1
    check("rdat_o", rd, ~32'h110);
    access(1'b1, 32'h014, 4'hf, $random(seed), rd, lat);
    access(1'b1, 32'h118, 4'b0011, $random(seed), rd, lat);
    access(1'b0, 32'h210, 4'hf, '0, rd, lat);      // repl bit names way 0
    check("rdat_o", rd, ~32'h210);
    check("bus beats", 32'(beat_adr.size()), 32'd8);
    check_burst(0, 32'h010, 1'b1);
    check_burst(4, 32'h210, 1'b0);
    for (int k = 0; k < 4; k++)
      check("memory word", mem0.mem[4+k], core_view[4+k]);
    access(1'b0, 32'h014, 4'hf, '0, rd, lat);      // evicts dirty 0x110
    check("rdat_o", rd, core_view[5]);
    check("bus beats", 32'(beat_adr.size()), 32'd8);
    check_burst(0, 32'h110, 1'b1);
    report("set conflict evict", e0);
  endtask

  task automatic inval_drops_dirty();
    logic [31:0] rd;
    int          lat;
    int          e0;
    e0 = errors;
    access(1'b0, 32'h80, 4'hf, '0, rd, lat);
    access(1'b1, 32'h84, 4'hf, $random(seed), rd, lat);
    @(posedge clk_i);
    inval_i <= 1'b1;                              // controller is idle here
    @(posedge clk_i);
    inval_i <= 1'b0;
    access(1'b0, 32'h84, 4'hf, '0, rd, lat);
    check("rdat_o", rd, ~32'h84);
    check("bus beats", 32'(beat_adr.size()), 32'd4);
    check_burst(0, 32'h80, 1'b0);
    report("invalidate drops dirty", e0);
  endtask

  //////////////////////////////////////////////////////////////
  // sequence and watchdog
  //////////////////////////////////////////////////////////////
  initial
  begin
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    inval_i = 1'b0;
    adr_i   = '0;
    be_i    = '0;
    wdat_i  = '0;
    for (int i = 0; i < 1024; i++)
      core_view[i] = ~(32'(i) << 2);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    cold_miss_read();
    same_line_hit();
    partial_write_hits();
    set_conflict_evict();
    inval_drops_dirty();
    if (mem0.range_err != 0)
    begin
      errors++;
      $display("memory model saw %0d bus beats outside its window", mem0.range_err);
    end
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    while (cycles < TIMEOUT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, controller in state %s", cycles,
             dut0.u_ctrl.state_q.name());
    $display("Verification failed");
    $finish;
  end

endmodule

// File: sources.f
logic/cache_pkg.sv
logic/cache_array_if.sv
logic/beat_counter.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/wb_mem_model.sv
verif/cache_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing --top-module cache_tb -f sources.f -o cache_sim
	./obj_dir/cache_sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
